// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= group_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: source/group_arbiter.sv
module group_arbiter (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                 [group_pkg::num_tiles-1:0]  req_valid_i,
  input  group_pkg::tcdm_addr_t [group_pkg::num_tiles-1:0] req_addr_i,
  output logic                 [group_pkg::num_tiles-1:0]  req_ready_o,
  output logic                 [group_pkg::num_tiles-1:0]  bank_gnt_o,
  output group_pkg::tile_idx_t [group_pkg::num_tiles-1:0]  bank_winner_o
);

  for (genvar b = 0; b < group_pkg::num_tiles; b++) begin : gen_bank_arb
    logic [group_pkg::num_tiles-1:0] bank_req;
    group_pkg::tile_idx_t            rr_ptr_q;
    group_pkg::tile_idx_t            winner;
    logic                            found;

    // Ports whose address selects this bank
    for (genvar p = 0; p < group_pkg::num_tiles; p++) begin : gen_req
      assign bank_req[p] = req_valid_i[p] &&
          (req_addr_i[p][group_pkg::tile_idx_width-1:0] == group_pkg::tile_idx_t'(b));
    end

    // First requester upward from the pointer, with wraparound
    always_comb begin
      group_pkg::tile_idx_t cand;
      found  = 1'b0;
      winner = rr_ptr_q;
      for (int unsigned off = 0; off < group_pkg::num_tiles; off++) begin
        cand = group_pkg::tile_idx_t'((rr_ptr_q + off) % group_pkg::num_tiles);
        if (!found && bank_req[cand]) begin
          found  = 1'b1;
          winner = cand;
        end
      end
    end

    // Pointer moves past the winner, holds while the bank is idle
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        rr_ptr_q <= '0;
      end else if (found) begin
        rr_ptr_q <= group_pkg::tile_idx_t'((winner + 1) % group_pkg::num_tiles);
      end
    end

    assign bank_gnt_o[b]    = found;
    assign bank_winner_o[b] = winner;
  end

  // Ready is the grant seen from the port side
  always_comb begin
    req_ready_o = '0;
    for (int unsigned b = 0; b < group_pkg::num_tiles; b++) begin
      if (bank_gnt_o[b]) begin
        req_ready_o[bank_winner_o[b]] = 1'b1;
      end
    end
  end

endmodule

// File: source/group_pkg.sv
package group_pkg;

  // Group geometry
  localparam int unsigned num_tiles       = 4;
  localparam int unsigned bank_words      = 16;

  // Word and byte-enable widths
  localparam int unsigned data_width      = 32;
  localparam int unsigned be_width        = data_width / 8;

  // Address split: bank select in the low bits, word offset above
  localparam int unsigned tile_idx_width  = 2;
  localparam int unsigned bank_addr_width = 4;
  localparam int unsigned tcdm_addr_width = tile_idx_width + bank_addr_width;

  // Bank select, or initiator index on the way back
  typedef logic [tile_idx_width-1:0] tile_idx_t;

  // Word address inside one bank
  typedef logic [bank_addr_width-1:0] bank_addr_t;

  // Group word address, low tile_idx_width bits pick the bank
  typedef logic [tcdm_addr_width-1:0] tcdm_addr_t;

  typedef logic [data_width-1:0] data_t;
  typedef logic [be_width-1:0] strb_t;

  // Request opcode
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } tcdm_op_e;

endpackage

// File: source/group_top.sv
module group_top (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  // Request side, one entry per port
  input  logic                  [group_pkg::num_tiles-1:0]  req_valid_i,
  output logic                  [group_pkg::num_tiles-1:0]  req_ready_o,
  input  group_pkg::tcdm_op_e   [group_pkg::num_tiles-1:0]  req_op_i,
  input  group_pkg::tcdm_addr_t [group_pkg::num_tiles-1:0]  req_addr_i,
  input  group_pkg::data_t      [group_pkg::num_tiles-1:0]  req_wdata_i,
  input  group_pkg::strb_t      [group_pkg::num_tiles-1:0]  req_be_i,
  // Read responses, one cycle after acceptance
  output logic                  [group_pkg::num_tiles-1:0]  resp_valid_o,
  output group_pkg::data_t      [group_pkg::num_tiles-1:0]  resp_rdata_o
);

  logic                 [group_pkg::num_tiles-1:0] bank_gnt;
  group_pkg::tile_idx_t [group_pkg::num_tiles-1:0] bank_winner;
  logic                 [group_pkg::num_tiles-1:0] bank_resp_valid;
  group_pkg::tile_idx_t [group_pkg::num_tiles-1:0] bank_resp_ini_addr;
  group_pkg::data_t     [group_pkg::num_tiles-1:0] bank_resp_rdata;

  tcdm_req_if bank_req [group_pkg::num_tiles] ();

  group_arbiter i_arbiter (
    .clk_i        (clk_i      ),
    .reset_i      (reset_i    ),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i ),
    .req_ready_o  (req_ready_o),
    .bank_gnt_o   (bank_gnt   ),
    .bank_winner_o(bank_winner)
  );

  tcdm_req_mux i_req_mux (
    .req_op_i     (req_op_i   ),
    .req_addr_i   (req_addr_i ),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i   ),
    .bank_gnt_i   (bank_gnt   ),
    .bank_winner_i(bank_winner),
    .bank_req     (bank_req   )
  );

  // One bank per tile
  for (genvar b = 0; b < group_pkg::num_tiles; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i          (clk_i                ),
      .reset_i        (reset_i              ),
      .req            (bank_req[b]          ),
      .resp_valid_o   (bank_resp_valid[b]   ),
      .resp_ini_addr_o(bank_resp_ini_addr[b]),
      .resp_rdata_o   (bank_resp_rdata[b]   )
    );
  end

  tcdm_resp_demux i_resp_demux (
    .bank_resp_valid_i   (bank_resp_valid   ),
    .bank_resp_ini_addr_i(bank_resp_ini_addr),
    .bank_resp_rdata_i   (bank_resp_rdata   ),
    .resp_valid_o        (resp_valid_o      ),
    .resp_rdata_o        (resp_rdata_o      )
  );

endmodule

// File: source/tcdm_bank.sv
module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 reset_i,
  tcdm_req_if.target           req,
  output logic                 resp_valid_o,
  output group_pkg::tile_idx_t resp_ini_addr_o,
  output group_pkg::data_t     resp_rdata_o
);

  group_pkg::data_t     mem_q [group_pkg::bank_words];
  group_pkg::data_t     rdata_q;
  group_pkg::tile_idx_t ini_addr_q;
  logic                 resp_valid_q;
  logic                 rd_en;
  logic                 wr_en;

  assign rd_en = req.valid && (req.op == group_pkg::op_read);
  assign wr_en = req.valid && (req.op == group_pkg::op_write);

  // Only enabled bytes are updated
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int unsigned i = 0; i < group_pkg::be_width; i++) begin
        if (req.be[i]) begin
          mem_q[req.bank_addr][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Read data and tag captured together
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q    <= mem_q[req.bank_addr];
      ini_addr_q <= req.ini_addr;
    end
  end

  // One-cycle response strobe, writes give none
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= rd_en;
    end
  end

  assign resp_valid_o    = resp_valid_q;
  assign resp_ini_addr_o = ini_addr_q;
  assign resp_rdata_o    = rdata_q;

endmodule

// File: source/tcdm_req_if.sv
interface tcdm_req_if;

  // Single-cycle strobe, fields only meaningful while high
  logic                    valid;
  group_pkg::tcdm_op_e     op;
  // Port that issued the request
  group_pkg::tile_idx_t    ini_addr;
  group_pkg::bank_addr_t   bank_addr;
  group_pkg::data_t        wdata;
  group_pkg::strb_t        be;

  modport initiator (
    output valid,
    output op,
    output ini_addr,
    output bank_addr,
    output wdata,
    output be
  );

  modport target (
    input valid,
    input op,
    input ini_addr,
    input bank_addr,
    input wdata,
    input be
  );

endinterface

// File: source/tcdm_req_mux.sv
module tcdm_req_mux (
  input  group_pkg::tcdm_op_e   [group_pkg::num_tiles-1:0] req_op_i,
  input  group_pkg::tcdm_addr_t [group_pkg::num_tiles-1:0] req_addr_i,
  input  group_pkg::data_t      [group_pkg::num_tiles-1:0] req_wdata_i,
  input  group_pkg::strb_t      [group_pkg::num_tiles-1:0] req_be_i,
  input  logic                  [group_pkg::num_tiles-1:0] bank_gnt_i,
  input  group_pkg::tile_idx_t  [group_pkg::num_tiles-1:0] bank_winner_i,
  tcdm_req_if.initiator                                    bank_req [group_pkg::num_tiles]
);

  for (genvar b = 0; b < group_pkg::num_tiles; b++) begin : gen_bank_mux
    group_pkg::tile_idx_t  sel;
    group_pkg::tcdm_addr_t sel_addr;

    assign sel      = bank_winner_i[b];
    assign sel_addr = req_addr_i[sel];

    assign bank_req[b].valid    = bank_gnt_i[b];
    assign bank_req[b].op       = req_op_i[sel];
    // Tag with the initiator so the response finds its way back
    assign bank_req[b].ini_addr = sel;
    // Bank select bits are dropped, only the word offset goes on
    assign bank_req[b].bank_addr =
        sel_addr[group_pkg::tcdm_addr_width-1:group_pkg::tile_idx_width];
    assign bank_req[b].wdata    = req_wdata_i[sel];
    assign bank_req[b].be       = req_be_i[sel];
  end

endmodule

// File: source/tcdm_resp_demux.sv
module tcdm_resp_demux (
  input  logic                 [group_pkg::num_tiles-1:0] bank_resp_valid_i,
  input  group_pkg::tile_idx_t [group_pkg::num_tiles-1:0] bank_resp_ini_addr_i,
  input  group_pkg::data_t     [group_pkg::num_tiles-1:0] bank_resp_rdata_i,
  output logic                 [group_pkg::num_tiles-1:0] resp_valid_o,
  output group_pkg::data_t     [group_pkg::num_tiles-1:0] resp_rdata_o
);

  // At most one bank answers a given port per cycle
  always_comb begin
    resp_valid_o = '0;
    resp_rdata_o = '0;
    for (int unsigned p = 0; p < group_pkg::num_tiles; p++) begin
      for (int unsigned b = 0; b < group_pkg::num_tiles; b++) begin
        if (bank_resp_valid_i[b] &&
            (bank_resp_ini_addr_i[b] == group_pkg::tile_idx_t'(p))) begin
          resp_valid_o[p] = 1'b1;
          resp_rdata_o[p] = bank_resp_rdata_i[b];
        end
      end
    end
  end

endmodule

// File: sources.f
source/group_pkg.sv
source/tcdm_req_if.sv
source/group_arbiter.sv
source/tcdm_req_mux.sv
source/tcdm_bank.sv
source/tcdm_resp_demux.sv
source/group_top.sv
tests/group_tb.sv

// File: tests/group_input.txt
# port op(0 read, 1 write) addr(hex) wdata(hex) be(hex)
# addr is the group word address, its low two bits pick the bank
0 1 04 0badf00d f
0 1 00 11111111 f
0 0 00 00000000 0
0 1 00 000000ab 1
0 1 00 00cd0000 4
0 0 00 00000000 0
0 0 04 00000000 0
0 1 00 5a5a5a5a a
0 0 00 00000000 0
1 1 11 cafe0001 f
1 1 10 22222222 f
1 0 10 00000000 0
1 1 10 0000ee00 2
1 1 10 77000000 8
1 0 10 00000000 0
1 0 11 00000000 0
1 1 10 a5a5a5a5 5
1 0 10 00000000 0
2 1 22 beef0002 f
2 1 20 33333333 f
2 0 20 00000000 0
2 1 20 000000c1 1
2 1 20 d2000000 8
2 0 20 00000000 0
2 0 22 00000000 0
2 1 20 0f0f0f0f 3
2 0 20 00000000 0
3 1 33 f00d0003 f
3 1 30 44444444 f
3 0 30 00000000 0
3 1 30 00990000 4
3 1 30 00008800 2
3 0 30 00000000 0
3 0 33 00000000 0
3 1 30 f0f0f0f0 c
3 0 30 00000000 0

// File: tests/group_tb.sv
module group_tb;

  localparam int unsigned clk_period   = 20;
  localparam int unsigned reset_cycles = 10;
  localparam int unsigned max_cycles   = 2000;
  localparam int unsigned num_ports    = group_pkg::num_tiles;
  localparam int unsigned mem_words    = 2 ** group_pkg::tcdm_addr_width;
  localparam string       input_file   = "tests/group_input.txt";

  typedef struct packed {
    logic                  write;
    group_pkg::tcdm_addr_t addr;
    group_pkg::data_t      wdata;
    group_pkg::strb_t      be;
  } req_t;

  logic                                  clk_i = 1'b0;
  logic                                  reset_i;
  logic                  [num_ports-1:0] req_valid_i;
  logic                  [num_ports-1:0] req_ready_o;
  group_pkg::tcdm_op_e   [num_ports-1:0] req_op_i;
  group_pkg::tcdm_addr_t [num_ports-1:0] req_addr_i;
  group_pkg::data_t      [num_ports-1:0] req_wdata_i;
  group_pkg::strb_t      [num_ports-1:0] req_be_i;
  logic                  [num_ports-1:0] resp_valid_o;
  group_pkg::data_t      [num_ports-1:0] resp_rdata_o;

  // Per-port request lists, issued in file order
  req_t                 req_q [num_ports][$];
  group_pkg::data_t     ref_mem [mem_words];
  int unsigned          rr_ptr [num_ports];
  int unsigned          gap_cnt [num_ports];
  int unsigned          wait_grants [num_ports];
  logic [num_ports-1:0] exp_resp_valid;
  group_pkg::data_t     exp_resp_data [num_ports];
  int unsigned          full_grant_cycles;

  always #(clk_period / 2) clk_i = ~clk_i;

  group_top DUT (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_op_i    (req_op_i    ),
    .req_addr_i  (req_addr_i  ),
    .req_wdata_i (req_wdata_i ),
    .req_be_i    (req_be_i    ),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o)
  );

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int unsigned bank_of(input group_pkg::tcdm_addr_t addr);
    return 32'(addr) % num_ports;
  endfunction

  // Byte lanes with a low enable keep the old value
  function automatic group_pkg::data_t merge_bytes(input group_pkg::data_t old_word,
                                                   input group_pkg::data_t new_word,
                                                   input group_pkg::strb_t be);
    group_pkg::data_t result;
    result = old_word;
    for (int i = 0; i < int'(group_pkg::be_width); i++) begin
      if (be[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  task automatic load_requests();
    int               fd;
    int               port;
    int               op;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [31:0]      be;
    logic [8*128-1:0] text_line;
    req_t             r;
    fd = $fopen(input_file, "r");
    if (fd == 0) begin
      $display("could not open the request file %s", input_file);
      $display(">>> FAIL");
      $fatal(1, "missing input file");
    end else begin
      // Comment and blank lines do not scan
      while ($fgets(text_line, fd) != 0) begin
        if ($sscanf(text_line, "%d %d %h %h %h", port, op, addr, wdata, be) == 5 &&
            port >= 0 && port < int'(num_ports)) begin
          r.write = (op != 0);
          r.addr  = group_pkg::tcdm_addr_t'(addr);
          r.wdata = wdata;
          r.be    = group_pkg::strb_t'(be);
          req_q[port].push_back(r);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_request(input int unsigned p, input req_t r);
    req_valid_i[p] = 1'b1;
    req_op_i[p]    = r.write ? group_pkg::op_write : group_pkg::op_read;
    req_addr_i[p]  = r.addr;
    req_wdata_i[p] = r.wdata;
    req_be_i[p]    = r.be;
  endtask

  task automatic drive_idle(input int unsigned p);
    req_valid_i[p] = 1'b0;
    req_op_i[p]    = group_pkg::op_read;
    req_addr_i[p]  = '0;
    req_wdata_i[p] = '0;
    req_be_i[p]    = '0;
  endtask

  // Reads accepted one cycle earlier must answer now, nothing else
  task automatic check_responses();
    check_eq(32'(resp_valid_o), 32'(exp_resp_valid), "response valid per port");
    for (int unsigned p = 0; p < num_ports; p++) begin
      if (exp_resp_valid[p]) begin
        check_eq(resp_rdata_o[p], exp_resp_data[p], "read data");
      end
    end
  endtask

  initial begin
    int unsigned          cycles;
    int unsigned          cand;
    int unsigned          winner;
    bit                   found;
    bit                   granted;
    bit                   busy;
    logic [num_ports-1:0] exp_ready;
    req_t                 r;

    void'($urandom(32'hd001));
    reset_i = 1'b1;
    for (int unsigned p = 0; p < num_ports; p++) begin
      drive_idle(p);
      rr_ptr[p]      = 0;
      gap_cnt[p]     = 0;
      wait_grants[p] = 0;
    end
    exp_resp_valid    = '0;
    full_grant_cycles = 0;
    load_requests();

    repeat (reset_cycles) begin
      @(negedge clk_i);
      check_eq(32'(resp_valid_o), 32'd0, "response valid during reset");
    end
    reset_i = 1'b0;

    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      for (int unsigned p = 0; p < num_ports; p++) begin
        if (req_q[p].size() != 0 && gap_cnt[p] == 0) begin
          drive_request(p, req_q[p][0]);
        end else begin
          drive_idle(p);
        end
      end
      #(clk_period / 4);
      check_responses();

      // Starvation bound counted on the grants the DUT gives
      for (int unsigned b = 0; b < num_ports; b++) begin
        granted = 1'b0;
        for (int unsigned q = 0; q < num_ports; q++) begin
          if (req_ready_o[q] && req_valid_i[q] && bank_of(req_addr_i[q]) == b) begin
            granted = 1'b1;
          end
        end
        if (granted) begin
          for (int unsigned q = 0; q < num_ports; q++) begin
            if (!req_ready_o[q] && req_valid_i[q] && bank_of(req_addr_i[q]) == b) begin
              wait_grants[q]++;
              check_eq(32'(wait_grants[q] <= num_ports - 1), 32'd1,
                       "grants seen by a waiting port");
            end
          end
        end
      end

      // Round-robin model, one pointer per bank
      exp_ready = '0;
      for (int unsigned b = 0; b < num_ports; b++) begin
        found  = 1'b0;
        winner = 0;
        for (int unsigned off = 0; off < num_ports; off++) begin
          cand = (rr_ptr[b] + off) % num_ports;
          if (!found && req_valid_i[cand] && bank_of(req_addr_i[cand]) == b) begin
            found  = 1'b1;
            winner = cand;
          end
        end
        if (found) begin
          exp_ready[winner] = 1'b1;
          rr_ptr[b] = (winner + 1) % num_ports;
        end
      end
      check_eq(32'(req_ready_o), 32'(exp_ready), "ready per port");
      if (exp_ready == '1) begin
        full_grant_cycles++;
      end

      // Accepted requests, distinct banks so order does not matter
      exp_resp_valid = '0;
      for (int unsigned p = 0; p < num_ports; p++) begin
        if (exp_ready[p]) begin
          r = req_q[p].pop_front();
          if (r.write) begin
            ref_mem[r.addr] = merge_bytes(ref_mem[r.addr], r.wdata, r.be);
          end else begin
            exp_resp_valid[p] = 1'b1;
            exp_resp_data[p]  = ref_mem[r.addr];
          end
          wait_grants[p] = 0;
          gap_cnt[p]     = $urandom % 3;
        end else if (gap_cnt[p] != 0) begin
          gap_cnt[p]--;
        end
      end

      busy = 1'b0;
      for (int unsigned p = 0; p < num_ports; p++) begin
        if (req_q[p].size() != 0) begin
          busy = 1'b1;
        end
      end
      cycles++;
      if (cycles > max_cycles) begin
        $display("timeout: requests still pending after %0d cycles", max_cycles);
        $display(">>> FAIL");
        $fatal(1, "request queues did not drain");
      end
      @(negedge clk_i);
    end

    // Last read responses after the queues drained
    for (int unsigned p = 0; p < num_ports; p++) begin
      drive_idle(p);
    end
    #(clk_period / 4);
    check_responses();

    if (full_grant_cycles > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("no cycle granted all four ports at once");
      $display(">>> FAIL");
      $fatal(1, "no parallel grant seen");
    end
  end

endmodule
